// File: tb.f
design/spi_pkg.sv
design/boot_pkg.sv
design/spi_master.sv
design/spi_arbiter.sv
design/flash_boot_loader.sv
design/tld_zxuno.sv
test/spi_device_model.sv
test/zxuno_checker.sv
test/tb_zxuno.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_zxuno
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "All tests passed!" $(LOG) && echo "Simulation PASSED" || \
		(echo "Simulation FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/tb_zxuno.sv
module tb_zxuno;
   timeunit 1ns;
   timeprecision 1ps;
   import spi_pkg::*;
   import boot_pkg::*;

   localparam int          CLK_DIV         = 2;
   localparam int          LED_HOLD        = 16;
   localparam flash_addr_t BOOT_FLASH_BASE = 24'h040000;
   localparam sram_addr_t  BOOT_SRAM_BASE  = 19'h08000;
   localparam int          BOOT_LEN        = 32;
   localparam int          N_HOST          = 12;
   // Worst case bytes times byte time times arbitration slack
   localparam int WD_CYCLES = (BOOT_LEN + 4 + N_HOST * 4) * 16 * CLK_DIV * 3 + 1000;

   logic       clk = 1'b0;
   logic       rst_n;
   logic       end_run;
   logic       sd_req;
   spi_req_t   sd_req_data;
   logic       sd_done;
   spi_rsp_t   sd_rsp_data;
   sram_addr_t sram_addr;
   spi_byte_t  sram_data;
   logic       sram_we_n;
   logic       boot_done;
   logic       flash_cs_n;
   logic       flash_clk;
   logic       flash_mosi;
   logic       flash_miso;
   logic       sd_cs_n;
   logic       sd_clk;
   logic       sd_mosi;
   logic       sd_miso;
   logic       testled;
   int         errors;
   integer     seed;
   int         len;

   always #50 clk = ~clk;

   tld_zxuno #(
      .CLK_DIV (CLK_DIV), .LED_HOLD (LED_HOLD), .BOOT_FLASH_BASE (BOOT_FLASH_BASE),
      .BOOT_SRAM_BASE (BOOT_SRAM_BASE), .BOOT_LEN (BOOT_LEN)
   ) tld_zxuno_i (
      .clk (clk), .rst_n (rst_n), .sd_req (sd_req), .sd_req_data (sd_req_data),
      .sd_done (sd_done), .sd_rsp_data (sd_rsp_data), .sram_addr (sram_addr),
      .sram_data (sram_data), .sram_we_n (sram_we_n), .boot_done (boot_done),
      .flash_cs_n (flash_cs_n), .flash_clk (flash_clk), .flash_mosi (flash_mosi),
      .flash_miso (flash_miso), .sd_cs_n (sd_cs_n), .sd_clk (sd_clk),
      .sd_mosi (sd_mosi), .sd_miso (sd_miso), .testled (testled)
   );

   spi_device_model #(.SD_MODE (1'b0)) flash_model_i (
      .cs_n (flash_cs_n), .sclk (flash_clk), .mosi (flash_mosi), .miso (flash_miso)
   );

   spi_device_model #(.SD_MODE (1'b1)) sd_model_i (
      .cs_n (sd_cs_n), .sclk (sd_clk), .mosi (sd_mosi), .miso (sd_miso)
   );

   zxuno_checker #(
      .LED_HOLD (LED_HOLD), .BOOT_FLASH_BASE (BOOT_FLASH_BASE),
      .BOOT_SRAM_BASE (BOOT_SRAM_BASE), .BOOT_LEN (BOOT_LEN), .N_HOST (N_HOST)
   ) checker_i (
      .clk (clk), .rst_n (rst_n), .end_run (end_run), .sd_req (sd_req),
      .sd_req_data (sd_req_data), .sd_done (sd_done), .sd_rsp_data (sd_rsp_data),
      .sram_addr (sram_addr), .sram_data (sram_data), .sram_we_n (sram_we_n),
      .boot_done (boot_done), .flash_cs_n (flash_cs_n), .flash_clk (flash_clk),
      .sd_cs_n (sd_cs_n), .sd_clk (sd_clk), .testled (testled), .errors (errors)
   );

   // Strobe one host byte and return 5 ns after the edge that shows sd_done
   task automatic send_host_byte(input spi_byte_t data, input logic last);
      sd_req           = 1'b1;
      // Arbiter must override this random dev field
      sd_req_data.dev  = spi_dev_e'(1'($random(seed)));
      sd_req_data.data = data;
      sd_req_data.last = last;
      @(posedge clk);
      #5 sd_req = 1'b0;
      do @(posedge clk); while (!sd_done);
      #5;
   endtask

   ////////////////////
   // Stimulus
   ////////////////////

   initial begin
      seed        = 50;
      rst_n       = 1'b0;
      end_run     = 1'b0;
      sd_req      = 1'b0;
      sd_req_data = '0;
      repeat (8) @(posedge clk);
      #5 rst_n = 1'b1;
      // First host byte goes out with reset release to collide with the loader
      for (int t = 0; t < N_HOST; t++) begin
         len = 1 + ($unsigned($random(seed)) % 4);
         for (int b = 0; b < len; b++) begin
            send_host_byte(8'($random(seed)), b == len - 1);
         end
      end
      while (!boot_done) @(posedge clk);
      // Let the LED drain out
      repeat (LED_HOLD + 4) @(posedge clk);
      end_run = 1'b1;
      #1;
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WD_CYCLES * 100);
      $display("Timeout after %0d cycles, the run did not finish", WD_CYCLES);
      $display("Test failures found");
      $finish;
   end

endmodule

// File: test/zxuno_checker.sv
module zxuno_checker #(
   parameter int                    LED_HOLD        = 16,
   parameter boot_pkg::flash_addr_t BOOT_FLASH_BASE = 24'h040000,
   parameter boot_pkg::sram_addr_t  BOOT_SRAM_BASE  = 19'h08000,
   parameter int                    BOOT_LEN        = 32,
   parameter int                    N_HOST          = 12
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 end_run,
   input  logic                 sd_req,
   input  spi_pkg::spi_req_t    sd_req_data,
   input  logic                 sd_done,
   input  spi_pkg::spi_rsp_t    sd_rsp_data,
   input  boot_pkg::sram_addr_t sram_addr,
   input  spi_pkg::spi_byte_t   sram_data,
   input  logic                 sram_we_n,
   input  logic                 boot_done,
   input  logic                 flash_cs_n,
   input  logic                 flash_clk,
   input  logic                 sd_cs_n,
   input  logic                 sd_clk,
   input  logic                 testled,
   output int                   errors
);
   timeunit 1ns;
   timeprecision 1ps;
   import spi_pkg::*;
   import boot_pkg::*;

   int        boot_err = 0;
   int        host_err = 0;
   int        cs_err   = 0;
   int        led_err  = 0;
   int        rst_err  = 0;
   int        end_err  = 0;
   int        wr_cnt   = 0;
   int        host_idx = 0;
   int        host_txn = 0;
   int        idle     = LED_HOLD + 1;
   logic      rst_seen      = 1'b0;
   logic      boot_done_q   = 1'b0;
   logic      flash_started = 1'b0;
   spi_req_t  host_cur;
   spi_byte_t host_prev;
   spi_byte_t exp_b;
   logic      exp_led;

   assign errors = boot_err + host_err + cs_err + led_err + rst_err + end_err;

   // Flash content rule
   function automatic spi_byte_t flash_rule(input flash_addr_t a);
      logic [31:0] v;
      v = 32'(a) * 32'd7 + 32'h5A;
      return v[7:0];
   endfunction

   function automatic int mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
      if (exp_v !== act_v) begin
         $display("FAIL %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
         return 1;
      end
      return 0;
   endfunction

   always @(posedge clk) begin
      if (!rst_n) begin
         // Idle pins once the first reset edge has gone by
         if (rst_seen) begin
            rst_err += mismatch("reset_flash_cs_n", 1, 32'(flash_cs_n));
            rst_err += mismatch("reset_sd_cs_n", 1, 32'(sd_cs_n));
            rst_err += mismatch("reset_flash_clk", 0, 32'(flash_clk));
            rst_err += mismatch("reset_sd_clk", 0, 32'(sd_clk));
            rst_err += mismatch("reset_sram_we_n", 1, 32'(sram_we_n));
            rst_err += mismatch("reset_sd_done", 0, 32'(sd_done));
            rst_err += mismatch("reset_boot_done", 0, 32'(boot_done));
            rst_err += mismatch("reset_testled", 0, 32'(testled));
         end
         rst_seen = 1'b1;
      end else begin
         ////////////////////
         // Chip selects
         ////////////////////
         if (!flash_cs_n && !sd_cs_n) begin
            cs_err++;
            $display("Both chip selects are low at %0t", $time);
         end
         if (!flash_cs_n) begin
            flash_started = 1'b1;
         end
         // Boot read is one long transaction
         if (flash_started && flash_cs_n && wr_cnt < BOOT_LEN - 1) begin
            cs_err++;
            $display("Flash chip select rose in the middle of the boot read at %0t", $time);
         end
         // Select comes up together with the done of the closing byte
         if (host_idx > 0 && sd_cs_n && !(sd_done && host_cur.last)) begin
            cs_err++;
            $display("SD chip select rose inside a host transaction at %0t", $time);
         end

         ////////////////////
         // Boot copy
         ////////////////////
         if (!sram_we_n) begin
            if (boot_done) begin
               boot_err++;
               $display("SRAM write seen after boot_done at %0t", $time);
            end
            boot_err += mismatch("boot_sram_addr",
                                 32'(BOOT_SRAM_BASE + sram_addr_t'(wr_cnt)), 32'(sram_addr));
            boot_err += mismatch("boot_sram_data",
                                 32'(flash_rule(BOOT_FLASH_BASE + flash_addr_t'(wr_cnt))),
                                 32'(sram_data));
            wr_cnt++;
         end
         if (boot_done && !boot_done_q) begin
            boot_err += mismatch("boot_write_count", BOOT_LEN, wr_cnt);
            // Host collided at reset and must have won a turn
            if (host_txn == 0) begin
               host_err++;
               $display("Boot copy finished before the first host transaction");
            end
         end
         boot_done_q = boot_done;

         ////////////////////
         // Host exchange
         ////////////////////
         if (sd_req) begin
            host_cur = sd_req_data;
         end
         if (sd_done) begin
            exp_b = (host_idx == 0) ? 8'hFF : (host_prev ^ 8'hA5);
            host_err += mismatch("host_rsp_data", 32'(exp_b), 32'(sd_rsp_data.data));
            host_prev = host_cur.data;
            if (host_cur.last) begin
               host_idx = 0;
               host_txn++;
            end else begin
               host_idx++;
            end
         end

         ////////////////////
         // Activity LED
         ////////////////////
         if (!flash_cs_n || !sd_cs_n) begin
            idle = 0;
         end else if (idle <= LED_HOLD) begin
            idle++;
         end
         exp_led = (idle <= LED_HOLD);
         led_err += mismatch("activity_led", 32'(exp_led), 32'(testled));
      end
   end

   // Closing checks and summary
   always @(posedge end_run) begin
      end_err += mismatch("boot_total_writes", BOOT_LEN, wr_cnt);
      end_err += mismatch("host_transactions", N_HOST, host_txn);
      $display("Error counts: boot %0d host %0d cs %0d led %0d reset %0d end %0d total %0d",
               boot_err, host_err, cs_err, led_err, rst_err, end_err,
               boot_err + host_err + cs_err + led_err + rst_err + end_err);
   end

endmodule

// File: test/spi_device_model.sv
module spi_device_model #(
   parameter bit SD_MODE = 1'b0
) (
   input  logic cs_n,
   input  logic sclk,
   input  logic mosi,
   output logic miso
);
   timeunit 1ns;
   timeprecision 1ps;
   import spi_pkg::*;
   import boot_pkg::*;

   // Byte position in the open transaction
   int          k      = 0;
   logic [2:0]  bits   = 3'd0;
   spi_byte_t   rx     = 8'h00;
   spi_byte_t   tx     = 8'hFF;
   flash_addr_t addr   = '0;
   logic        cmd_ok = 1'b0;
   spi_byte_t   done_b;
   logic [31:0] calc;

   // Next reply bit MSB first
   assign miso = tx[3'd7 - bits];

   ////////////////////
   // Serial side
   ////////////////////

   always @(posedge sclk or posedge cs_n) begin
      if (cs_n) begin
         // Deselect starts a new transaction
         k    = 0;
         bits = 3'd0;
         tx   = 8'hFF;
      end else begin
         rx   = {rx[6:0], mosi};
         bits = bits + 3'd1;
         if (bits == 3'd0) begin
            done_b = rx;
            k      = k + 1;
            if (SD_MODE) begin
               // Scrambled echo of the last byte
               tx = done_b ^ 8'hA5;
            end else begin
               // Only the read command opens the array
               if (k == 1) begin
                  cmd_ok = (done_b == flash_cmd_read);
               end
               // Bytes 1 to 3 carry the address
               if (k >= 2 && k <= 4) begin
                  addr = {addr[15:0], done_b};
               end
               if (k >= 4 && cmd_ok) begin
                  calc = (32'(addr) + 32'(k - 4)) * 32'd7 + 32'h5A;
                  tx   = calc[7:0];
               end else begin
                  tx = 8'hFF;
               end
            end
         end
      end
   end

endmodule

// File: design/tld_zxuno.sv
module tld_zxuno #(
   parameter int                    CLK_DIV         = 2,
   parameter int                    LED_HOLD        = 16,
   parameter boot_pkg::flash_addr_t BOOT_FLASH_BASE = 24'h040000,
   parameter boot_pkg::sram_addr_t  BOOT_SRAM_BASE  = 19'h08000,
   parameter int                    BOOT_LEN        = 32
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 sd_req,
   input  spi_pkg::spi_req_t    sd_req_data,
   output logic                 sd_done,
   output spi_pkg::spi_rsp_t    sd_rsp_data,
   output boot_pkg::sram_addr_t sram_addr,
   output spi_pkg::spi_byte_t   sram_data,
   output logic                 sram_we_n,
   output logic                 boot_done,
   output logic                 flash_cs_n,
   output logic                 flash_clk,
   output logic                 flash_mosi,
   input  logic                 flash_miso,
   output logic                 sd_cs_n,
   output logic                 sd_clk,
   output logic                 sd_mosi,
   input  logic                 sd_miso,
   output logic                 testled
);
   import spi_pkg::*;

   // Loader port of the arbiter
   logic     ldr_req;
   spi_req_t ldr_req_data;
   logic     ldr_done;
   spi_rsp_t ldr_rsp;

   // Arbiter to master
   logic     m_start;
   spi_req_t m_req;
   logic     m_done;
   spi_rsp_t m_rsp;
   logic     m_busy;

   // Shared serial lines
   logic     spi_clk;
   logic     mosi;
   logic     miso;

   ////////////////////
   // Pin fan-out
   ////////////////////

   assign flash_clk  = spi_clk;
   assign sd_clk     = spi_clk;
   assign flash_mosi = mosi;
   assign sd_mosi    = mosi;
   // Selected device drives miso
   assign miso       = !flash_cs_n ? flash_miso : sd_miso;

   ////////////////////
   // Storage peers
   ////////////////////

   flash_boot_loader #(
      .BOOT_FLASH_BASE (BOOT_FLASH_BASE),
      .BOOT_SRAM_BASE  (BOOT_SRAM_BASE),
      .BOOT_LEN        (BOOT_LEN)
   ) boot_loader_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (ldr_req),
      .req_data  (ldr_req_data),
      .done      (ldr_done),
      .rsp       (ldr_rsp),
      .sram_addr (sram_addr),
      .sram_data (sram_data),
      .sram_we_n (sram_we_n),
      .boot_done (boot_done)
   );

   spi_arbiter arbiter_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .boot_req      (ldr_req),
      .boot_req_data (ldr_req_data),
      .boot_done     (ldr_done),
      .boot_rsp      (ldr_rsp),
      .host_req      (sd_req),
      .host_req_data (sd_req_data),
      .host_done     (sd_done),
      .host_rsp      (sd_rsp_data),
      .m_start       (m_start),
      .m_req         (m_req),
      .m_done        (m_done),
      .m_rsp         (m_rsp),
      .m_busy        (m_busy)
   );

   spi_master #(
      .CLK_DIV  (CLK_DIV),
      .LED_HOLD (LED_HOLD)
   ) master_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (m_start),
      .req        (m_req),
      .done       (m_done),
      .rsp        (m_rsp),
      .busy       (m_busy),
      .spi_clk    (spi_clk),
      .mosi       (mosi),
      .miso       (miso),
      .flash_cs_n (flash_cs_n),
      .sd_cs_n    (sd_cs_n),
      .testled    (testled)
   );

endmodule

// File: design/flash_boot_loader.sv
module flash_boot_loader #(
   parameter boot_pkg::flash_addr_t BOOT_FLASH_BASE = 24'h040000,
   parameter boot_pkg::sram_addr_t  BOOT_SRAM_BASE  = 19'h08000,
   parameter int                    BOOT_LEN        = 32
) (
   input  logic                 clk,
   input  logic                 rst_n,
   output logic                 req,
   output spi_pkg::spi_req_t    req_data,
   input  logic                 done,
   input  spi_pkg::spi_rsp_t    rsp,
   output boot_pkg::sram_addr_t sram_addr,
   output spi_pkg::spi_byte_t   sram_data,
   output logic                 sram_we_n,
   output logic                 boot_done
);
   import spi_pkg::*;
   import boot_pkg::*;

   localparam int CNT_W = (BOOT_LEN > 1) ? $clog2(BOOT_LEN) : 1;

   typedef enum logic [2:0] {
      st_cmd,
      st_addr_hi,
      st_addr_mid,
      st_addr_lo,
      st_data,
      st_finished
   } state_e;

   state_e           state;
   logic             pending;
   logic [CNT_W-1:0] cnt;
   logic             last_byte;

   assign last_byte = (cnt == CNT_W'(BOOT_LEN - 1));

   // Strobe once per byte, then wait for its done
   assign req = (state != st_finished) && !pending;

   ////////////////////
   // Outgoing byte
   ////////////////////

   always_comb begin
      req_data.dev  = dev_flash;
      req_data.last = 1'b0;
      case (state)
         st_cmd:      req_data.data = flash_cmd_read;
         st_addr_hi:  req_data.data = BOOT_FLASH_BASE[23:16];
         st_addr_mid: req_data.data = BOOT_FLASH_BASE[15:8];
         st_addr_lo:  req_data.data = BOOT_FLASH_BASE[7:0];
         st_data: begin
            // Dummy byte clocks data out of the flash
            req_data.data = 8'hFF;
            req_data.last = last_byte;
         end
         default:     req_data.data = '0;
      endcase
   end

   ////////////////////
   // Boot FSM
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= st_cmd;
         pending   <= 1'b0;
         cnt       <= '0;
         sram_we_n <= 1'b1;
         boot_done <= 1'b0;
      end else begin
         sram_we_n <= 1'b1;
         if (req) begin
            pending <= 1'b1;
         end else if (done) begin
            pending <= 1'b0;
         end
         if (done) begin
            case (state)
               st_cmd:      state <= st_addr_hi;
               st_addr_hi:  state <= st_addr_mid;
               st_addr_mid: state <= st_addr_lo;
               st_addr_lo:  state <= st_data;
               st_data: begin
                  // Write strobe lands one cycle after done
                  sram_we_n <= 1'b0;
                  cnt       <= cnt + CNT_W'(1);
                  if (last_byte) begin
                     state <= st_finished;
                  end
               end
               default:     state <= state;
            endcase
         end
         // One cycle behind the final SRAM write
         if (state == st_finished) begin
            boot_done <= 1'b1;
         end
      end
   end

   // SRAM address and data for the pending write
   always_ff @(posedge clk) begin
      if (done && state == st_data) begin
         sram_data <= rsp.data;
         sram_addr <= BOOT_SRAM_BASE + sram_addr_t'(cnt);
      end
   end

endmodule

// File: design/spi_arbiter.sv
module spi_arbiter (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              boot_req,
   input  spi_pkg::spi_req_t boot_req_data,
   output logic              boot_done,
   output spi_pkg::spi_rsp_t boot_rsp,
   input  logic              host_req,
   input  spi_pkg::spi_req_t host_req_data,
   output logic              host_done,
   output spi_pkg::spi_rsp_t host_rsp,
   output logic              m_start,
   output spi_pkg::spi_req_t m_req,
   input  logic              m_done,
   input  spi_pkg::spi_rsp_t m_rsp,
   input  logic              m_busy
);
   import spi_pkg::*;

   // Port identity is the device it is stamped with
   logic     pend_boot;
   logic     pend_host;
   spi_req_t boot_q;
   spi_req_t host_q;
   logic     open_q;
   spi_dev_e owner;
   spi_dev_e last_served;
   logic     in_flight;
   spi_dev_e pick;
   logic     pick_pend;
   logic     issue;
   spi_req_t fwd;

   ////////////////////
   // Grant selection
   ////////////////////

   always_comb begin
      // Open transaction locks the owner in
      if (open_q) begin
         pick = owner;
      end else if (pend_boot && pend_host) begin
         pick = (last_served == dev_flash) ? dev_sd : dev_flash;
      end else if (pend_host) begin
         pick = dev_sd;
      end else begin
         pick = dev_flash;
      end
      pick_pend = (pick == dev_sd) ? pend_host : pend_boot;

      // Device forced from the port, caller's dev ignored
      fwd     = (pick == dev_sd) ? host_q : boot_q;
      fwd.dev = pick;
   end

   // One byte in the master at a time
   assign issue = pick_pend && !in_flight && !m_busy;

   ////////////////////
   // Control state
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pend_boot   <= 1'b0;
         pend_host   <= 1'b0;
         open_q      <= 1'b0;
         owner       <= dev_flash;
         // Host wins a tie straight out of reset
         last_served <= dev_flash;
         in_flight   <= 1'b0;
         m_start     <= 1'b0;
         boot_done   <= 1'b0;
         host_done   <= 1'b0;
      end else begin
         m_start   <= issue;
         boot_done <= m_done && (owner == dev_flash);
         host_done <= m_done && (owner == dev_sd);

         if (boot_req) begin
            pend_boot <= 1'b1;
         end else if (issue && pick == dev_flash) begin
            pend_boot <= 1'b0;
         end
         if (host_req) begin
            pend_host <= 1'b1;
         end else if (issue && pick == dev_sd) begin
            pend_host <= 1'b0;
         end

         if (issue) begin
            in_flight <= 1'b1;
            open_q    <= 1'b1;
            owner     <= pick;
            // Fairness only counts new transactions
            if (!open_q) begin
               last_served <= pick;
            end
         end else if (m_done) begin
            in_flight <= 1'b0;
            if (m_req.last) begin
               open_q <= 1'b0;
            end
         end
      end
   end

   ////////////////////
   // Payload registers
   ////////////////////

   always_ff @(posedge clk) begin
      if (boot_req) begin
         boot_q <= boot_req_data;
      end
      if (host_req) begin
         host_q <= host_req_data;
      end
      if (issue) begin
         m_req <= fwd;
      end
      // Response goes back to the owner only
      if (m_done && owner == dev_flash) begin
         boot_rsp <= m_rsp;
      end
      if (m_done && owner == dev_sd) begin
         host_rsp <= m_rsp;
      end
   end

endmodule

// File: design/spi_master.sv
module spi_master #(
   parameter int CLK_DIV  = 2,
   parameter int LED_HOLD = 16
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              start,
   input  spi_pkg::spi_req_t req,
   output logic              done,
   output spi_pkg::spi_rsp_t rsp,
   output logic              busy,
   output logic              spi_clk,
   output logic              mosi,
   input  logic              miso,
   output logic              flash_cs_n,
   output logic              sd_cs_n,
   output logic              testled
);
   import spi_pkg::*;

   localparam int DIV_W  = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
   localparam int HOLD_W = $clog2(LED_HOLD + 1);

   typedef enum logic [1:0] {
      st_idle,
      st_shift,
      st_finish
   } state_e;

   state_e            state;
   logic [DIV_W-1:0]  div_cnt;
   logic [3:0]        edge_cnt;
   logic              tick;
   spi_byte_t         shreg;
   logic              miso_q;
   logic              last_q;
   logic [HOLD_W-1:0] led_cnt;
   logic              cs_active;

   // Half-period of spi_clk elapsed
   assign tick = (div_cnt == DIV_W'(CLK_DIV - 1));

   ////////////////////
   // Byte FSM and chip selects
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= st_idle;
         div_cnt    <= '0;
         edge_cnt   <= '0;
         spi_clk    <= 1'b0;
         last_q     <= 1'b0;
         flash_cs_n <= 1'b1;
         sd_cs_n    <= 1'b1;
      end else begin
         case (state)
            st_idle: begin
               if (start) begin
                  state    <= st_shift;
                  // Preload by one so the 16th edge lands one cycle before done
                  div_cnt  <= (CLK_DIV > 1) ? DIV_W'(1) : '0;
                  edge_cnt <= '0;
                  last_q   <= req.last;
                  // Only the addressed device is selected
                  flash_cs_n <= (req.dev != dev_flash);
                  sd_cs_n    <= (req.dev != dev_sd);
               end
            end
            st_shift: begin
               if (tick) begin
                  div_cnt  <= '0;
                  spi_clk  <= ~spi_clk;
                  edge_cnt <= edge_cnt + 4'd1;
                  // 8 rising plus 8 falling edges per byte
                  if (edge_cnt == 4'd15) begin
                     state <= st_finish;
                  end
               end else begin
                  div_cnt <= div_cnt + DIV_W'(1);
               end
            end
            st_finish: begin
               state <= st_idle;
               // Release after the closing byte, else keep the device selected
               if (last_q) begin
                  flash_cs_n <= 1'b1;
                  sd_cs_n    <= 1'b1;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   ////////////////////
   // Shift register
   ////////////////////

   // Mode 0, sample on rising edge, shift on falling edge
   always_ff @(posedge clk) begin
      if (state == st_idle && start) begin
         shreg <= req.data;
      end else if (state == st_shift && tick) begin
         if (!spi_clk) begin
            miso_q <= miso;
         end else begin
            shreg <= {shreg[6:0], miso_q};
         end
      end
   end

   // MSB first
   assign mosi     = shreg[7];
   assign rsp.data = shreg;
   assign done     = (state == st_finish);
   assign busy     = (state != st_idle);

   ////////////////////
   // Activity LED
   ////////////////////

   assign cs_active = !flash_cs_n || !sd_cs_n;

   // Reload while selected, drain once both selects are high
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         led_cnt <= '0;
      end else if (cs_active) begin
         led_cnt <= HOLD_W'(LED_HOLD);
      end else if (led_cnt != '0) begin
         led_cnt <= led_cnt - HOLD_W'(1);
      end
   end

   assign testled = cs_active || (led_cnt != '0);

endmodule

// File: design/boot_pkg.sv
package boot_pkg;

   ////////////////////
   // Memory map
   ////////////////////

   // Byte address inside the boot flash
   typedef logic [23:0] flash_addr_t;

   // External SRAM address, 512K bytes
   typedef logic [18:0] sram_addr_t;

   ////////////////////
   // Flash commands
   ////////////////////

   // Plain read, three address bytes follow, MSB first
   localparam logic [7:0] flash_cmd_read = 8'h03;

endpackage

// File: design/spi_pkg.sv
package spi_pkg;

   // One byte on the serial link
   typedef logic [7:0] spi_byte_t;

   // Which device the SPI master talks to
   typedef enum logic {
      dev_flash = 1'b0,
      dev_sd    = 1'b1
   } spi_dev_e;

   ////////////////////
   // Byte request and response
   ////////////////////

   // Last set closes the transaction and frees the chip select
   typedef struct packed {
      spi_dev_e  dev;
      spi_byte_t data;
      logic      last;
   } spi_req_t;

   // Byte shifted in from miso during the exchange
   typedef struct packed {
      spi_byte_t data;
   } spi_rsp_t;

endpackage
